//--- source/router_rx_pkg.sv
package router_rx_pkg;

	// link byte timing
	localparam int OVERSAMPLE   = 8;  // baud ticks per byte slot
	localparam int SAMPLE_PHASE = 3;  // tick in slot where the byte is taken

	// frame layout: start, payload, stop
	localparam int FRAME_BYTES = 16;
	localparam int FRAME_SLOTS = 18;  // start + 16 data + stop
	localparam int DATA_W      = 128; // payload bits

	localparam logic [7:0] START_BYTE = 8'h00;
	localparam logic [7:0] STOP_BYTE  = 8'hFF;

	// merge side
	localparam int FIFO_DEPTH = 4; // frame entries, power of two
	localparam int LINK_W     = 1; // two links

	// receiver FSM
	typedef enum logic {
		RX_IDLE,  // hunting for a start byte
		RX_COUNT  // inside a frame, counting ticks
	} rx_state_e;

	// one finished frame, also the FIFO entry
	typedef struct packed {
		logic [DATA_W-1:0] data;      // first data byte in [7:0]
		logic [LINK_W-1:0] link;      // source link, set by the merge block
		logic              frame_err; // stop byte was not 0xFF
	} rx_frame_t;

endpackage

//--- source/link_frame_rx.sv
`timescale 1ns/1ps

module link_frame_rx import router_rx_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       baud_ce_i,   // oversample tick
	input  logic       clear_i,     // back to idle, drops overrun
	input  logic [7:0] rxd_i,       // raw link byte, async to clk_i
	input  logic       frame_ack_i, // from the merge block
	output logic       frame_req_o, // four-phase req
	output rx_frame_t  frame_o,     // held while req is high
	output logic       overrun_o    // sticky until clear_i
);

	logic [7:0]               rxd_sync [4]; // synchronizer chain
	logic [7:0]               rxd_s;        // synchronized byte
	rx_state_e                state_q;
	logic [7:0]               cnt_q;        // tick count inside the frame
	logic [FRAME_BYTES*8-1:0] shift_q;      // payload assembly
	logic [DATA_W-1:0]        frame_data_q; // latched payload
	logic                     frame_err_q;
	logic                     tick_sample;  // sample phase of any slot
	logic                     tick_stop;    // sample phase of the stop slot
	logic                     tick_end;     // two ticks past the stop check
	logic                     frame_done;   // stop check happens this clock
	logic                     hs_idle;      // previous handshake finished

	assign rxd_s = rxd_sync[3];

	// slot 17 phase 3 -> 0x8B
	assign tick_sample = (cnt_q % 8'(OVERSAMPLE)) == 8'(SAMPLE_PHASE);
	assign tick_stop   = cnt_q == 8'((FRAME_SLOTS - 1) * OVERSAMPLE + SAMPLE_PHASE);
	assign tick_end    = cnt_q == 8'((FRAME_SLOTS - 1) * OVERSAMPLE + SAMPLE_PHASE + 2);

	assign frame_done = baud_ce_i && !clear_i && (state_q == RX_COUNT) && tick_stop;
	assign hs_idle    = !frame_req_o && !frame_ack_i; // req and ack both low

	// four flops, byte seen by the FSM four clocks after the pin
	always_ff @(posedge clk_i) begin
		rxd_sync[0] <= rxd_i;
		for (int i = 1; i < 4; i++) begin
			rxd_sync[i] <= rxd_sync[i-1];
		end
	end

	// frame FSM and tick counter
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= RX_IDLE;
			cnt_q     <= '0;
			overrun_o <= 1'b0;
		end else if (clear_i) begin
			state_q   <= RX_IDLE;
			cnt_q     <= '0;
			overrun_o <= 1'b0;
		end else if (baud_ce_i) begin
			case (state_q)
				RX_IDLE: begin
					cnt_q <= '0; // count starts at 0 on the next tick
					if (rxd_s == START_BYTE)
						state_q <= RX_COUNT;
				end
				RX_COUNT: begin
					cnt_q <= cnt_q + 8'd1;
					// start byte gone by its sample point
					if (cnt_q == 8'(SAMPLE_PHASE) && rxd_s != START_BYTE)
						state_q <= RX_IDLE;
					if (tick_stop && !hs_idle)
						overrun_o <= 1'b1; // old frame still unacked, drop this one
					if (tick_end)
						state_q <= RX_IDLE;
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk_i) begin
		if (baud_ce_i && state_q == RX_COUNT && tick_sample)
			shift_q <= {rxd_s, shift_q[FRAME_BYTES*8-1:8]}; // new byte enters at the top
		// at the stop tick the start byte has already left the bottom
		if (frame_done && hs_idle) begin
			frame_data_q <= shift_q;
			frame_err_q  <= rxd_s != STOP_BYTE;
		end
	end

	// req side of the handshake, clear_i leaves a pending req alone
	always_ff @(posedge clk_i) begin
		if (rst_i)
			frame_req_o <= 1'b0;
		else if (frame_req_o && frame_ack_i)
			frame_req_o <= 1'b0; // phase 3
		else if (frame_done && hs_idle)
			frame_req_o <= 1'b1; // phase 1, frame already latched
	end

	// link number is stamped by the merge block
	assign frame_o = '{data: frame_data_q, link: '0, frame_err: frame_err_q};

endmodule

//--- source/frame_merge_fifo.sv
`timescale 1ns/1ps

module frame_merge_fifo import router_rx_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// receiver lanes
	input  logic [1:0]           frame_req_i,
	input  rx_frame_t [1:0]      frame_i,
	output logic [1:0]           frame_ack_o,
	// bus read port
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 cs_i,
	input  logic                 we_i,  // only qualifies reads
	output logic                 ack_o,
	output logic [DATA_W-1:0]    dat_o, // head payload
	// head status
	output logic [LINK_W-1:0]    head_link_o,
	output logic                 head_err_o,
	output logic                 data_present_o
);

	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(FIFO_DEPTH):0]   cnt_t;

	rx_frame_t  fifo_mem [FIFO_DEPTH];
	ptr_t       wr_ptr_q;
	ptr_t       rd_ptr_q;
	ptr_t       head_ptr;
	cnt_t       count_q;
	logic       fifo_full;
	logic       fifo_empty;
	logic [1:0] pend;      // req up, ack not yet given
	logic       rr_ptr_q;  // preferred link on a tie
	logic       gnt_valid;
	logic       gnt_idx;
	rx_frame_t  wr_entry;
	rx_frame_t  head;
	logic       sel;       // chip select
	logic       sel_q;
	logic       rd_sel;
	logic       rd_sel_q;
	logic       pop;
	logic       data_present_q;

	assign fifo_full  = count_q == cnt_t'(FIFO_DEPTH);
	assign fifo_empty = count_q == '0;

	// arbitration
	assign pend = frame_req_i & ~frame_ack_o;

	always_comb begin
		gnt_valid = (|pend) && !fifo_full; // full FIFO holds ack back
		if (&pend)
			gnt_idx = rr_ptr_q; // tie goes to the round-robin pointer
		else
			gnt_idx = pend[1];
	end

	always_comb begin
		wr_entry      = frame_i[gnt_idx];
		wr_entry.link = LINK_W'(gnt_idx); // stamp source lane
	end

	// ack side of both handshakes
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			frame_ack_o <= '0;
			rr_ptr_q    <= 1'b0; // link 0 first after reset
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (frame_ack_o[i] && !frame_req_i[i])
					frame_ack_o[i] <= 1'b0; // phase 4
			end
			if (gnt_valid) begin
				frame_ack_o[gnt_idx] <= 1'b1; // phase 2, entry written same edge
				rr_ptr_q             <= ~gnt_idx;
			end
		end
	end

	// bus select and read edge
	assign sel    = cyc_i & stb_i & cs_i;
	assign rd_sel = sel & ~we_i;
	assign pop    = rd_sel & ~rd_sel_q & ~fifo_empty; // empty read pops nothing
	assign ack_o  = sel ? sel_q : 1'b0;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sel_q    <= 1'b0;
			rd_sel_q <= 1'b0;
		end else begin
			sel_q    <= sel;
			rd_sel_q <= rd_sel;
		end
	end

	// ring buffer pointers and fill level
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q       <= '0;
			rd_ptr_q       <= '0;
			count_q        <= '0;
			data_present_q <= 1'b0;
		end else begin
			if (gnt_valid)
				wr_ptr_q <= wr_ptr_q + ptr_t'(1);
			if (pop)
				rd_ptr_q <= rd_ptr_q + ptr_t'(1);
			count_q        <= count_q + cnt_t'(gnt_valid) - cnt_t'(pop);
			data_present_q <= !fifo_empty; // lags the write by a clock
		end
	end

	always_ff @(posedge clk_i) begin
		if (gnt_valid)
			fifo_mem[wr_ptr_q] <= wr_entry;
	end

	// empty: keep showing the last popped entry
	assign head_ptr = fifo_empty ? rd_ptr_q - ptr_t'(1) : rd_ptr_q;
	assign head     = fifo_mem[head_ptr];

	assign dat_o          = head.data;
	assign head_link_o    = head.link;
	assign head_err_o     = head.frame_err;
	assign data_present_o = data_present_q;

endmodule

//--- source/router_rx_top.sv
`timescale 1ns/1ps

module router_rx_top import router_rx_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_i,
	// bus
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              cs_i,
	input  logic              we_i,
	output logic              ack_o,
	output logic [DATA_W-1:0] dat_o,
	// head status
	output logic [LINK_W-1:0] head_link_o,
	output logic              head_err_o,
	output logic              data_present_o,
	// links
	input  logic              baud_ce_i, // shared by both receivers
	input  logic              clear_i,
	input  logic [7:0]        rxd0_i,
	input  logic [7:0]        rxd1_i,
	output logic [1:0]        overrun_o  // bit per link
);

	logic [1:0]      rx_req; // receiver -> merge
	logic [1:0]      rx_ack; // merge -> receiver
	rx_frame_t [1:0] rx_frame;

	link_frame_rx rx0 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.baud_ce_i   (baud_ce_i),
		.clear_i     (clear_i),
		.rxd_i       (rxd0_i),
		.frame_ack_i (rx_ack[0]),
		.frame_req_o (rx_req[0]),
		.frame_o     (rx_frame[0]),
		.overrun_o   (overrun_o[0])
	);

	link_frame_rx rx1 (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.baud_ce_i   (baud_ce_i),
		.clear_i     (clear_i),
		.rxd_i       (rxd1_i),
		.frame_ack_i (rx_ack[1]),
		.frame_req_o (rx_req[1]),
		.frame_o     (rx_frame[1]),
		.overrun_o   (overrun_o[1])
	);

	frame_merge_fifo merge0 (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.frame_req_i    (rx_req),
		.frame_i        (rx_frame),
		.frame_ack_o    (rx_ack),
		.cyc_i          (cyc_i),
		.stb_i          (stb_i),
		.cs_i           (cs_i),
		.we_i           (we_i),
		.ack_o          (ack_o),
		.dat_o          (dat_o),
		.head_link_o    (head_link_o),
		.head_err_o     (head_err_o),
		.data_present_o (data_present_o)
	);

endmodule

//--- dv/router_rx_properties.sv
`timescale 1ns/1ps

module router_rx_properties import router_rx_pkg::*; (
	input logic            clk_i,
	input logic            rst_i,
	input logic [1:0]      frame_req_i,
	input rx_frame_t [1:0] frame_i,
	input logic [1:0]      frame_ack_o,
	input logic            cyc_i,
	input logic            stb_i,
	input logic            cs_i,
	input logic            ack_o
);

	int unsigned fail_cnt = 0; // failed assertion count
	logic        sel;

	assign sel = cyc_i && stb_i && cs_i; // same select as the bus port

	for (genvar i = 0; i < 2; i++) begin : g_lane
		frame_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
			(frame_req_i[i] && $past(frame_req_i[i])) |-> $stable(frame_i[i]))
		else begin
			$error("lane %0d frame changed while req was high", i);
			fail_cnt++;
		end

		// phase 3 only after phase 2
		req_fall_a: assert property (@(posedge clk_i) disable iff (rst_i)
			$fell(frame_req_i[i]) |-> $past(frame_ack_o[i]))
		else begin
			$error("lane %0d req dropped without ack", i);
			fail_cnt++;
		end

		ack_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(frame_ack_o[i]) |-> $past(frame_req_i[i]))
		else begin
			$error("lane %0d ack raised without req", i);
			fail_cnt++;
		end
	end

	// registered bus ack
	ack_follow_a: assert property (@(posedge clk_i) disable iff (rst_i)
		sel |-> (ack_o == $past(sel)))
	else begin
		$error("ack_o not one cycle behind select");
		fail_cnt++;
	end

	ack_low_a: assert property (@(posedge clk_i) disable iff (rst_i) !sel |-> !ack_o)
	else begin
		$error("ack_o high without select");
		fail_cnt++;
	end

endmodule

bind frame_merge_fifo router_rx_properties props0 (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.frame_req_i (frame_req_i),
	.frame_i     (frame_i),
	.frame_ack_o (frame_ack_o),
	.cyc_i       (cyc_i),
	.stb_i       (stb_i),
	.cs_i        (cs_i),
	.ack_o       (ack_o)
);

//--- dv/router_rx_tb.sv
`timescale 1ns/1ps

module router_rx_tb import router_rx_pkg::*; ();

	localparam int CLK_HALF   = 20;
	localparam int SLOT_CLKS  = OVERSAMPLE * 4; // baud_ce every fourth clock
	localparam int NUM_FRAMES = 13;             // false start counted as a frame
	localparam int TIMEOUT    = NUM_FRAMES * FRAME_SLOTS * OVERSAMPLE * 4 * 2 + 2000;

	logic              clk;
	logic              rst;
	logic              cyc;
	logic              stb;
	logic              cs;
	logic              we;
	logic              baud_ce;
	logic              clear;
	logic [7:0]        rxd0;
	logic [7:0]        rxd1;
	logic              ack;
	logic [DATA_W-1:0] dat;
	logic [LINK_W-1:0] head_link;
	logic              head_err;
	logic              data_present;
	logic [1:0]        overrun;

	int unsigned       errors    = 0;
	logic [31:0]       lcg_state = 32'd14872;
	logic              rr_model  = 1'b0; // expected tie winner
	rx_frame_t         exp_q[$];         // frames in expected read order

	router_rx_top dut0 (
		.clk_i (clk), .rst_i (rst),
		.cyc_i (cyc), .stb_i (stb), .cs_i (cs), .we_i (we),
		.ack_o (ack), .dat_o (dat),
		.head_link_o (head_link), .head_err_o (head_err), .data_present_o (data_present),
		.baud_ce_i (baud_ce), .clear_i (clear),
		.rxd0_i (rxd0), .rxd1_i (rxd1), .overrun_o (overrun)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [DATA_W-1:0] random_payload();
		logic [DATA_W-1:0] p;
		for (int i = 0; i < DATA_W / 32; i++)
			p[32*i +: 32] = lcg_next();
		return p;
	endfunction

	// round-robin model of the merge arbiter
	// a single grant moves rr_model to the other link
	function automatic void expect_frames(input logic [1:0] lanes, input logic [DATA_W-1:0] d0,
			input logic [DATA_W-1:0] d1, input logic err);
		rx_frame_t f [2];
		f[0] = '{data: d0, link: 1'b0, frame_err: err};
		f[1] = '{data: d1, link: 1'b1, frame_err: err};
		if (lanes == 2'b11) begin
			exp_q.push_back(f[rr_model]);
			exp_q.push_back(f[!rr_model]); // pointer ends where it started
		end else begin
			exp_q.push_back(f[lanes[1]]);
			rr_model = !lanes[1];
		end
	endfunction

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_v,
			input logic [DATA_W-1:0] got_v);
		errors++;
		$display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, got_v);
	endtask

	// called on a falling edge
	task automatic drive_slot(input logic [1:0] lanes, input logic [7:0] b0, input logic [7:0] b1);
		rxd0 = lanes[0] ? b0 : 8'hFF; // idle line is 0xFF
		rxd1 = lanes[1] ? b1 : 8'hFF;
		repeat (SLOT_CLKS) @(negedge clk);
	endtask

	task automatic send_frames(input logic [1:0] lanes, input logic [DATA_W-1:0] d0,
			input logic [DATA_W-1:0] d1, input logic [7:0] stop);
		@(negedge clk);
		drive_slot(lanes, START_BYTE, START_BYTE);
		for (int i = 0; i < FRAME_BYTES; i++)
			drive_slot(lanes, d0[8*i +: 8], d1[8*i +: 8]); // byte 0 first
		drive_slot(lanes, stop, stop);
		drive_slot(2'b00, 8'hFF, 8'hFF); // idle gap lets the FSM return to RX_IDLE
		drive_slot(2'b00, 8'hFF, 8'hFF);
	endtask

	task automatic wait_present();
		while (!data_present)
			@(negedge clk);
	endtask

	// head checked before the pop edge of a two-cycle read select
	task automatic read_check();
		rx_frame_t exp_f;
		@(negedge clk);
		if (exp_q.size() == 0) begin
			errors++;
			$display("a read was issued with no frame left to expect");
		end else begin
			exp_f = exp_q.pop_front();
			{cyc, stb, cs, we} = 4'b1110;
			assert (dat == exp_f.data) else report_mismatch("dat_o", exp_f.data, dat);
			assert (head_link == exp_f.link)
				else report_mismatch("head_link_o", DATA_W'(exp_f.link), DATA_W'(head_link));
			assert (head_err == exp_f.frame_err)
				else report_mismatch("head_err_o", DATA_W'(exp_f.frame_err), DATA_W'(head_err));
			@(negedge clk);
			assert (ack) else report_mismatch("ack_o", DATA_W'(1), DATA_W'(ack));
			@(negedge clk);
			// select still held, so no second pop
			assert (ack) else report_mismatch("ack_o", DATA_W'(1), DATA_W'(ack));
			{cyc, stb, cs} = 3'b000; // drop select between reads
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// one baud tick in four clocks
	initial begin
		int div;
		div     = 0;
		baud_ce = 1'b0;
		forever begin
			@(negedge clk);
			div     = (div + 1) % 4;
			baud_ce = div == 0;
		end
	end

	initial begin
		repeat (TIMEOUT) @(posedge clk);
		$display("timeout: the run did not finish within %0d clocks", TIMEOUT);
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] pay_a;
		logic [DATA_W-1:0] pay_b;
		rst = 1'b1;
		{cyc, stb, cs, we} = 4'b0000;
		clear = 1'b0;
		rxd0  = 8'hFF;
		rxd1  = 8'hFF;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		pay_a = random_payload(); // good frame on link 0
		send_frames(2'b01, pay_a, '0, STOP_BYTE);
		expect_frames(2'b01, pay_a, '0, 1'b0);
		wait_present();
		read_check();

		pay_a = random_payload(); // bad stop byte on link 1
		send_frames(2'b10, '0, pay_a, 8'hA5);
		expect_frames(2'b10, '0, pay_a, 1'b1);
		wait_present();
		read_check();

		@(negedge clk);
		rxd0 = START_BYTE; // held two ticks only
		repeat (8) @(negedge clk);
		rxd0 = 8'hFF;
		repeat ((FRAME_SLOTS + 2) * SLOT_CLKS) @(negedge clk);
		assert (!data_present) else report_mismatch("data_present_o", '0, DATA_W'(1));

		pay_a = random_payload(); // both links at once
		pay_b = random_payload();
		send_frames(2'b11, pay_a, pay_b, STOP_BYTE);
		expect_frames(2'b11, pay_a, pay_b, 1'b0);
		wait_present();
		read_check();
		read_check();

		// fifth frame stalls in its handshake and the sixth is dropped
		for (int n = 0; n < 6; n++) begin
			pay_a = random_payload();
			send_frames(2'b01, pay_a, '0, STOP_BYTE);
			if (n < 5)
				expect_frames(2'b01, pay_a, '0, 1'b0);
		end
		assert (overrun == 2'b01) else report_mismatch("overrun_o", DATA_W'(1), DATA_W'(overrun));
		@(negedge clk);
		clear = 1'b1;
		@(negedge clk);
		clear = 1'b0;
		assert (overrun == 2'b00) else report_mismatch("overrun_o", '0, DATA_W'(overrun));

		repeat (5)
			read_check(); // stalled frame comes last
		repeat (2) @(negedge clk);
		assert (!data_present) else report_mismatch("data_present_o", '0, DATA_W'(1));

		pay_a = random_payload(); // second tie with the pointer on link 1
		pay_b = random_payload();
		send_frames(2'b11, pay_a, pay_b, STOP_BYTE);
		expect_frames(2'b11, pay_a, pay_b, 1'b0);
		wait_present();
		read_check();
		read_check();

		$display("%0d value errors, %0d assertion failures", errors,
			dut0.merge0.props0.fail_cnt);
		if (errors == 0 && dut0.merge0.props0.fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- compile.f
source/router_rx_pkg.sv
source/link_frame_rx.sv
source/frame_merge_fifo.sv
source/router_rx_top.sv
dv/router_rx_properties.sv
dv/router_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of router_rx_tb
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module router_rx_tb \
	-f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vrouter_rx_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
